// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module hdd_tb \
		-f hdd.f --Mdir obj_dir -o hdd_sim

run: compile
	./obj_dir/hdd_sim

clean:
	rm -rf obj_dir

// ==== hdd.f ====
src/hdd_pkg.sv
src/hdd_bus_regs.sv
src/hdd_cmd_fsm.sv
src/hdd_byte_counter.sv
src/hdd_sector_buffer.sv
src/hdd_top.sv
sim/hdd_tb.sv

// ==== sim/hdd_tb.sv ====
`timescale 1ns/1ps

module hdd_tb;

    localparam int BUF_ADDR_W   = 9;
    localparam int SECTOR_BYTES = 1 << BUF_ADDR_W;

    logic                  CLK_14M = 1'b0;
    logic                  RESET;
    logic                  phi0;
    logic                  DEVICE_SELECT;
    logic [15:0]           A;
    logic                  RD;
    logic [7:0]            D_IN;
    logic [7:0]            D_OUT;
    logic [15:0]           sector;
    logic                  hdd_read;
    logic                  hdd_write;
    logic                  hdd_mounted;
    logic                  hdd_protect;
    logic [BUF_ADDR_W-1:0] ram_addr;
    logic [7:0]            ram_di;
    logic [7:0]            ram_do;
    logic                  ram_we;

    integer     seed;
    string      test_name = "setup";
    logic [7:0] expect_buf [0:SECTOR_BYTES-1];   // Sector contents the host should see
    logic [7:0] reg_vals   [3:7];
    int         read_pulses  = 0;
    int         write_pulses = 0;

    hdd_top #(.BUF_ADDR_W(BUF_ADDR_W)) i_dut (
        .CLK_14M(CLK_14M), .RESET(RESET), .phi0(phi0), .DEVICE_SELECT(DEVICE_SELECT),
        .A(A), .RD(RD), .D_IN(D_IN), .D_OUT(D_OUT), .sector(sector),
        .hdd_read(hdd_read), .hdd_write(hdd_write), .hdd_mounted(hdd_mounted),
        .hdd_protect(hdd_protect), .ram_addr(ram_addr), .ram_di(ram_di),
        .ram_do(ram_do), .ram_we(ram_we)
    );

    always #50 CLK_14M = ~CLK_14M;   // 100 ns period

    // Count host strobes per high clock
    always @(posedge CLK_14M) begin
        if (hdd_read) read_pulses <= read_pulses + 1;
        if (hdd_write) write_pulses <= write_pulses + 1;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %h, actual %h",
                     test_name, name, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // One bus cycle from falling edge to falling edge
    task automatic cpu_access(input logic [15:0] addr, input logic rd,
                              input logic [7:0] data, output logic [7:0] q);
        DEVICE_SELECT = 1'b1;
        phi0          = 1'b1;
        A             = addr;
        RD            = rd;
        D_IN          = data;
        repeat (3) @(posedge CLK_14M);
        @(negedge CLK_14M);
        q = D_OUT;
        @(negedge CLK_14M);
        DEVICE_SELECT = 1'b0;
        phi0          = 1'b0;
        RD            = 1'b1;
        repeat (2) @(negedge CLK_14M);
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] q;
        cpu_access(addr, 1'b0, data, q);
        check("d_out during write", 16'h00FF, 16'(q));
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] q);
        cpu_access(addr, 1'b1, 8'h00, q);
    endtask

    task automatic dma_write(input logic [BUF_ADDR_W-1:0] addr, input logic [7:0] data);
        ram_addr = addr;
        ram_di   = data;
        ram_we   = 1'b1;
        @(negedge CLK_14M);
        ram_we   = 1'b0;
    endtask

    task automatic dma_read(input logic [BUF_ADDR_W-1:0] addr, output logic [7:0] data);
        ram_addr = addr;
        @(negedge CLK_14M);
        data = ram_do;   // One clock of read latency
    endtask

    task automatic await_strobe(input bit is_write, input int target);
        int n;
        n = 0;
        while ((is_write ? write_pulses : read_pulses) < target && n < 20) begin
            @(negedge CLK_14M);
            n++;
        end
        if ((is_write ? write_pulses : read_pulses) < target) begin
            $display("Timed out waiting for the hdd_%s strobe", is_write ? "write" : "read");
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic fill_expected();
        logic [31:0] rnd;
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            rnd = $random(seed);
            expect_buf[i] = rnd[7:0];
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic reset_and_registers();
        logic [7:0]  q;
        logic [31:0] rnd;
        test_name = "reset_and_registers";
        check("reset d_out", 16'h00FF, 16'(D_OUT));
        check("reset sector", 16'h0000, sector);
        check("reset strobes", 16'h0000, 16'({hdd_read, hdd_write}));
        bus_read(16'hC0F2, q);
        check("reset command", 16'h0000, 16'(q));
        for (int r = 3; r <= 7; r++) begin
            rnd = $random(seed);
            reg_vals[r] = rnd[7:0];
            bus_write(16'hC0F0 + 16'(r), reg_vals[r]);
        end
        for (int r = 3; r <= 7; r++) begin
            bus_read(16'hC0F0 + 16'(r), q);
            check("register readback", 16'(reg_vals[r]), 16'(q));
        end
        check("idle d_out", 16'h00FF, 16'(D_OUT));
        bus_read(16'hC0F9, q);
        check("unused offset", 16'h00FF, 16'(q));
        check("sector", {reg_vals[7], reg_vals[6]}, sector);
    endtask

    task automatic status_command();
        logic [7:0] q;
        test_name = "status_command";
        bus_write(16'hC0F2, 8'h00);
        bus_read(16'hC0F0, q);
        check("status mounted", 16'h0000, 16'(q));
        hdd_mounted = 1'b0;
        bus_read(16'hC0F0, q);
        check("status unmounted reply", 16'h0001, 16'(q));
        bus_read(16'hC0F1, q);
        check("status unmounted status", 16'h0001, 16'(q));
        hdd_mounted = 1'b1;
    endtask

    task automatic read_command();
        logic [7:0] q;
        int         pulses;
        test_name = "read_command";
        pulses = read_pulses;
        bus_write(16'hC0F2, 8'h01);
        bus_read(16'hC0F1, q);
        check("read busy", 16'h0080, 16'(q));
        bus_read(16'hC0F0, q);
        check("read reply", 16'h0080, 16'(q));
        await_strobe(1'b0, pulses + 1);
        check("read pulse count", 16'(pulses + 1), 16'(read_pulses));
        fill_expected();
        for (int i = 0; i < SECTOR_BYTES; i++) dma_write(i[BUF_ADDR_W-1:0], expect_buf[i]);
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            if (i == SECTOR_BYTES - 1) begin
                bus_read(16'hC0F1, q);
                check("read busy before last", 16'h0080, 16'(q));
            end
            bus_read(16'hC0F8, q);
            check("read stream", 16'(expect_buf[i]), 16'(q));
        end
        bus_read(16'hC0F1, q);
        check("read done", 16'h0000, 16'(q));
        // Unmounted disk must not start a transfer
        hdd_mounted = 1'b0;
        pulses = read_pulses;
        bus_write(16'hC0F2, 8'h01);
        bus_read(16'hC0F0, q);
        check("read unmounted reply", 16'h0001, 16'(q));
        repeat (4) @(negedge CLK_14M);
        check("read unmounted pulse", 16'(pulses), 16'(read_pulses));
        hdd_mounted = 1'b1;
    endtask

    task automatic write_command();
        logic [7:0] q;
        int         pulses;
        test_name = "write_command";
        pulses = write_pulses;
        fill_expected();
        bus_write(16'hC0F2, 8'h02);
        for (int i = 0; i < SECTOR_BYTES; i++) bus_write(16'hC0F8, expect_buf[i]);
        bus_read(16'hC0F0, q);
        check("write reply", 16'h0000, 16'(q));
        await_strobe(1'b1, pulses + 1);
        check("write pulse count", 16'(pulses + 1), 16'(write_pulses));
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            dma_read(i[BUF_ADDR_W-1:0], q);
            check("write dma data", 16'(expect_buf[i]), 16'(q));
        end
    endtask

    task automatic write_protect();
        logic [7:0] q;
        int         pulses;
        test_name = "write_protect";
        pulses = write_pulses;
        hdd_protect = 1'b1;
        bus_write(16'hC0F2, 8'h02);
        bus_read(16'hC0F0, q);
        check("protect reply", 16'h002B, 16'(q));
        bus_read(16'hC0F1, q);
        check("protect status", 16'h0001, 16'(q));
        repeat (4) @(negedge CLK_14M);
        check("protect pulse", 16'(pulses), 16'(write_pulses));
        hdd_protect = 1'b0;
    endtask

    task automatic counter_restart();
        logic [7:0] q;
        int         pulses;
        test_name = "counter_restart";
        pulses = read_pulses;
        bus_write(16'hC0F2, 8'h01);
        bus_read(16'hC0F0, q);
        await_strobe(1'b0, pulses + 1);
        for (int i = 0; i < 5; i++) begin
            bus_read(16'hC0F8, q);
            check("restart prefix", 16'(expect_buf[i]), 16'(q));
        end
        bus_write(16'hC0F2, 8'h01);   // Clears the byte counter
        bus_read(16'hC0F8, q);
        check("restart first byte", 16'(expect_buf[0]), 16'(q));
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        seed          = 32'hd0ea;
        RESET         = 1'b1;
        phi0          = 1'b0;
        DEVICE_SELECT = 1'b0;
        A             = 16'h0000;
        RD            = 1'b1;
        D_IN          = 8'h00;
        hdd_mounted   = 1'b1;
        hdd_protect   = 1'b0;
        ram_addr      = '0;
        ram_di        = 8'h00;
        ram_we        = 1'b0;
        repeat (3) @(posedge CLK_14M);
        @(negedge CLK_14M);
        RESET = 1'b0;

        reset_and_registers();
        status_command();
        read_command();
        write_command();
        write_protect();
        counter_restart();

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== src/hdd_bus_regs.sv ====
`timescale 1ns/1ps

module hdd_bus_regs (
    input  logic        CLK_14M,
    input  logic        RESET,
    input  logic        phi0,
    input  logic        DEVICE_SELECT,
    input  logic [3:0]  A,
    input  logic        RD,
    input  logic [7:0]  D_IN,
    input  logic [7:0]  status,
    input  logic [7:0]  reply,
    input  logic [7:0]  cpu_q,
    output logic [7:0]  D_OUT,
    output logic [15:0] sector,
    output logic [7:0]  cmd,
    output logic        exec_strobe,
    output logic        cmd_write,
    output logic        next_read,
    output logic        next_write,
    output logic        next_step
);
    import hdd_pkg::*;

    logic       sel_done;      // Access already taken for this select
    logic       access;
    logic [7:0] reg_command;
    logic [7:0] reg_unit;
    logic [7:0] reg_mem_l;
    logic [7:0] reg_mem_h;
    logic [7:0] reg_block_l;
    logic [7:0] reg_block_h;
    logic [7:0] next_hold;     // Byte at the offset before the step
    logic [7:0] rd_mux;

    // ------------------------------------------------------------
    // One access per select, on the first phi0 clock
    // ------------------------------------------------------------
    assign access = DEVICE_SELECT && phi0 && !sel_done;

    always_ff @(posedge CLK_14M) begin
        if (RESET || !DEVICE_SELECT) begin
            sel_done <= 1'b0;
        end else if (access) begin
            sel_done <= 1'b1;
        end
    end

    assign exec_strobe = access &&  RD && (A == REG_EXEC);
    assign cmd_write   = access && !RD && (A == REG_COMMAND);
    assign next_read   = access &&  RD && (A == REG_NEXT_BYTE);
    assign next_write  = access && !RD && (A == REG_NEXT_BYTE);
    assign next_step   = next_read || next_write;

    // The FSM sees the new command in the same clock as the write
    assign cmd    = cmd_write ? D_IN : reg_command;
    assign sector = {reg_block_h, reg_block_l};

    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            reg_command <= 8'h00;
            reg_unit    <= 8'h00;
            reg_mem_l   <= 8'h00;
            reg_mem_h   <= 8'h00;
            reg_block_l <= 8'h00;
            reg_block_h <= 8'h00;
        end else if (access && !RD) begin
            case (A)
                REG_COMMAND: reg_command <= D_IN;
                REG_UNIT:    reg_unit    <= D_IN;
                REG_MEM_L:   reg_mem_l   <= D_IN;
                REG_MEM_H:   reg_mem_h   <= D_IN;
                REG_BLOCK_L: reg_block_l <= D_IN;
                REG_BLOCK_H: reg_block_h <= D_IN;
                default:     ;                    // Status and execute are read-only
            endcase
        end
    end

    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            next_hold <= 8'h00;
        end else if (next_read) begin
            next_hold <= cpu_q;
        end
    end

    // ------------------------------------------------------------
    // Read data
    // ------------------------------------------------------------
    always_comb begin
        case (A)
            REG_EXEC:      rd_mux = reply;
            REG_STATUS:    rd_mux = status;
            REG_COMMAND:   rd_mux = reg_command;
            REG_UNIT:      rd_mux = reg_unit;
            REG_MEM_L:     rd_mux = reg_mem_l;
            REG_MEM_H:     rd_mux = reg_mem_h;
            REG_BLOCK_L:   rd_mux = reg_block_l;
            REG_BLOCK_H:   rd_mux = reg_block_h;
            REG_NEXT_BYTE: rd_mux = next_hold;
            default:       rd_mux = BUS_IDLE;
        endcase
    end

    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            D_OUT <= BUS_IDLE;
        end else begin
            D_OUT <= (DEVICE_SELECT && RD) ? rd_mux : BUS_IDLE;
        end
    end

    // Each access yields at most one side-effect pulse
    a_one_pulse: assert property (@(posedge CLK_14M) disable iff (RESET)
        $onehot0({exec_strobe, cmd_write, next_read, next_write}));

endmodule

// ==== src/hdd_byte_counter.sv ====
`timescale 1ns/1ps

module hdd_byte_counter #(
    parameter int BUF_ADDR_W = 9
) (
    input  logic                  CLK_14M,
    input  logic                  RESET,
    input  logic                  clear,
    input  logic                  step,
    output logic [BUF_ADDR_W-1:0] offset,
    output logic                  last
);

    // Offset into the sector wraps past the last byte
    always_ff @(posedge CLK_14M) begin
        if (RESET || clear) begin
            offset <= '0;
        end else if (step) begin
            offset <= offset + 1'b1;
        end
    end

    assign last = &offset;   // Final byte of the sector

    // A command write and a NEXT BYTE access never share a clock
    a_clear_step: assert property (@(posedge CLK_14M) disable iff (RESET)
        !(clear && step));

endmodule

// ==== src/hdd_cmd_fsm.sv ====
`timescale 1ns/1ps

module hdd_cmd_fsm (
    input  logic              CLK_14M,
    input  logic              RESET,
    input  hdd_pkg::hdd_cmd_e cmd,
    input  logic              cmd_write,
    input  logic              exec_strobe,
    input  logic              next_read,
    input  logic              last,
    input  logic              hdd_mounted,
    input  logic              hdd_protect,
    output logic [7:0]        status,
    output logic [7:0]        reply,
    output logic              hdd_read,
    output logic              hdd_write
);
    import hdd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_ARMED,
        ST_READ_STREAM,
        ST_WRITE_ARMED
    } state_e;

    state_e state;

    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            state     <= ST_IDLE;
            status    <= ST_OK;
            reply     <= ST_OK;
            hdd_read  <= 1'b0;
            hdd_write <= 1'b0;
        end else begin
            hdd_read  <= 1'b0;   // Host strobes last one clock
            hdd_write <= 1'b0;

            if (cmd_write) begin
                case (cmd)
                    CMD_READ: begin
                        status <= ST_BUSY;
                        state  <= ST_READ_ARMED;
                    end
                    CMD_WRITE: begin
                        status <= ST_BUSY;
                        state  <= ST_WRITE_ARMED;
                    end
                    default: begin               // STATUS, FORMAT and unknown codes
                        status <= ST_OK;
                        state  <= ST_IDLE;
                    end
                endcase
            end else if (exec_strobe) begin
                if (cmd == CMD_STATUS) begin
                    status <= hdd_mounted ? ST_OK : ST_ERROR;
                    reply  <= hdd_mounted ? ST_OK : ST_ERROR;
                end else begin
                    case (state)
                        ST_READ_ARMED: begin
                            if (hdd_mounted) begin
                                hdd_read <= 1'b1;
                                reply    <= status;   // Still busy until the stream ends
                                state    <= ST_READ_STREAM;
                            end else begin
                                status <= ST_ERROR;
                                reply  <= ST_ERROR;
                                state  <= ST_IDLE;
                            end
                        end
                        ST_WRITE_ARMED: begin
                            if (hdd_protect) begin
                                status <= ST_ERROR;
                                reply  <= ST_PROTECT;
                            end else if (hdd_mounted) begin
                                hdd_write <= 1'b1;
                                status    <= ST_OK;
                                reply     <= ST_OK;
                            end else begin
                                status <= ST_ERROR;
                                reply  <= ST_ERROR;
                            end
                            state <= ST_IDLE;
                        end
                        default: reply <= status;
                    endcase
                end
            end else if (state == ST_READ_STREAM && next_read && last) begin
                status <= ST_OK;                 // Last byte of the sector taken
                state  <= ST_IDLE;
            end
        end
    end

    // ------------------------------------------------------------
    // Host strobe checks
    // ------------------------------------------------------------
    a_strobe_excl: assert property (@(posedge CLK_14M) disable iff (RESET)
        !(hdd_read && hdd_write));
    a_read_pulse: assert property (@(posedge CLK_14M) disable iff (RESET)
        hdd_read |=> !hdd_read);
    a_write_pulse: assert property (@(posedge CLK_14M) disable iff (RESET)
        hdd_write |=> !hdd_write);

endmodule

// ==== src/hdd_pkg.sv ====
package hdd_pkg;

    // ------------------------------------------------------------
    // ProDOS command codes written to C0F2
    // ------------------------------------------------------------
    typedef enum logic [7:0] {
        CMD_STATUS = 8'h00,
        CMD_READ   = 8'h01,
        CMD_WRITE  = 8'h02,
        CMD_FORMAT = 8'h03
    } hdd_cmd_e;

    // Register offsets within the device select window, from A[3:0]
    typedef enum logic [3:0] {
        REG_EXEC      = 4'h0,   // Read runs the command
        REG_STATUS    = 4'h1,
        REG_COMMAND   = 4'h2,
        REG_UNIT      = 4'h3,
        REG_MEM_L     = 4'h4,
        REG_MEM_H     = 4'h5,
        REG_BLOCK_L   = 4'h6,
        REG_BLOCK_H   = 4'h7,
        REG_NEXT_BYTE = 4'h8    // Sector data stream
    } hdd_reg_e;

    // ------------------------------------------------------------
    // Status and reply bytes
    // ------------------------------------------------------------
    localparam logic [7:0] ST_OK      = 8'h00;
    localparam logic [7:0] ST_ERROR   = 8'h01;
    localparam logic [7:0] ST_BUSY    = 8'h80;
    localparam logic [7:0] ST_PROTECT = 8'h2B;   // ProDOS write-protected error

    localparam logic [7:0] BUS_IDLE   = 8'hFF;   // Floating data bus

endpackage

// ==== src/hdd_sector_buffer.sv ====
`timescale 1ns/1ps

module hdd_sector_buffer #(
    parameter int BUF_ADDR_W = 9
) (
    input  logic                  CLK_14M,
    // DMA port, host side
    input  logic                  ram_we,
    input  logic [BUF_ADDR_W-1:0] ram_addr,
    input  logic [7:0]            ram_di,
    output logic [7:0]            ram_do,
    // CPU port, NEXT BYTE stream
    input  logic                  cpu_we,
    input  logic [BUF_ADDR_W-1:0] cpu_addr,
    input  logic [7:0]            cpu_di,
    output logic [7:0]            cpu_q
);

    logic [7:0] mem [0:(1 << BUF_ADDR_W)-1];

    // ------------------------------------------------------------
    // Both ports write synchronously and read with one clock latency
    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_di;
        end
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_di;
        end
        ram_do <= mem[ram_addr];   // Old data on a same-clock write
        cpu_q  <= mem[cpu_addr];
    end

endmodule

// ==== src/hdd_top.sv ====
`timescale 1ns/1ps

module hdd_top #(
    parameter int BUF_ADDR_W = 9
) (
    input  logic                  CLK_14M,
    input  logic                  RESET,
    input  logic                  phi0,
    input  logic                  DEVICE_SELECT,
    input  logic [15:0]           A,
    input  logic                  RD,
    input  logic [7:0]            D_IN,
    output logic [7:0]            D_OUT,
    output logic [15:0]           sector,
    output logic                  hdd_read,
    output logic                  hdd_write,
    input  logic                  hdd_mounted,
    input  logic                  hdd_protect,
    input  logic [BUF_ADDR_W-1:0] ram_addr,
    input  logic [7:0]            ram_di,
    output logic [7:0]            ram_do,
    input  logic                  ram_we
);
    import hdd_pkg::*;

    logic [7:0]            status;
    logic [7:0]            reply;
    logic [7:0]            cmd;
    logic                  exec_strobe;
    logic                  cmd_write;
    logic                  next_read;
    logic                  next_write;
    logic                  next_step;
    logic [BUF_ADDR_W-1:0] offset;
    logic                  last;
    logic [7:0]            cpu_q;

    // The slot select already covers A[15:4]
    hdd_bus_regs u_bus_regs (
        .CLK_14M(CLK_14M), .RESET(RESET), .phi0(phi0), .DEVICE_SELECT(DEVICE_SELECT),
        .A(A[3:0]), .RD(RD), .D_IN(D_IN), .status(status), .reply(reply), .cpu_q(cpu_q),
        .D_OUT(D_OUT), .sector(sector), .cmd(cmd), .exec_strobe(exec_strobe),
        .cmd_write(cmd_write), .next_read(next_read), .next_write(next_write),
        .next_step(next_step)
    );

    hdd_cmd_fsm u_cmd_fsm (
        .CLK_14M(CLK_14M), .RESET(RESET), .cmd(hdd_cmd_e'(cmd)), .cmd_write(cmd_write),
        .exec_strobe(exec_strobe), .next_read(next_read), .last(last),
        .hdd_mounted(hdd_mounted), .hdd_protect(hdd_protect), .status(status),
        .reply(reply), .hdd_read(hdd_read), .hdd_write(hdd_write)
    );

    hdd_byte_counter #(.BUF_ADDR_W(BUF_ADDR_W)) u_byte_counter (
        .CLK_14M(CLK_14M), .RESET(RESET), .clear(cmd_write), .step(next_step),
        .offset(offset), .last(last)
    );

    hdd_sector_buffer #(.BUF_ADDR_W(BUF_ADDR_W)) u_sector_buffer (
        .CLK_14M(CLK_14M), .ram_we(ram_we), .ram_addr(ram_addr), .ram_di(ram_di),
        .ram_do(ram_do), .cpu_we(next_write), .cpu_addr(offset), .cpu_di(D_IN),
        .cpu_q(cpu_q)
    );

endmodule
